// ==== source/uartPkg.sv ====
`default_nettype none

package uartPkg;

  // FIFO geometry
  localparam int FifoDepth = 4;
  localparam int FifoAddrLen = 2;

  typedef logic [7:0] byteT;
  typedef logic [15:0] baudT;
  typedef logic [15:0] timerT;
  typedef logic [1:0] regAddrT;

  // Register map
  localparam regAddrT AddrCtrl = 2'd0;
  localparam regAddrT AddrBaud = 2'd1;
  localparam regAddrT AddrData = 2'd2;
  localparam regAddrT AddrTimeout = 2'd3;

  // Timeout tick sources
  localparam logic [1:0] TimerSrcStop = 2'd0;
  localparam logic [1:0] TimerSrc1K = 2'd1;
  localparam logic [1:0] TimerSrc1M = 2'd2;
  localparam logic [1:0] TimerSrcClk = 2'd3;

  typedef struct packed {
    logic write;
    regAddrT addr;
    logic [15:0] wdata;
  } busReqT;

  typedef struct packed {
    logic txEn;
    logic rxEn;
    logic [1:0] timerSrc;
    logic twoStop;
    logic timerAutoRestart;
    logic [1:0] irqEn;
  } uartCtrlT;

  typedef struct packed {
    logic canWrite;
    logic canRead;
  } fifoFlagsT;

  typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} rxStateT;

endpackage

`default_nettype wire

// ==== source/uartRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartRegs (
  input wire clkH,
  input wire reset,
  input wire req,
  input wire uartPkg::busReqT busReq,
  input wire uartPkg::fifoFlagsT txFlags,
  input wire uartPkg::fifoFlagsT rxFlags,
  input wire uartPkg::byteT rxHead,
  input wire sendBusy,
  input wire uartPkg::timerT timerThis,
  input wire timerNz,
  output logic ack,
  output logic [15:0] rdata,
  output uartPkg::uartCtrlT ctrl,
  output uartPkg::baudT baud,
  output logic txPush,
  output logic rxPop,
  output logic timerLoad,
  output logic irq
);
  import uartPkg::*;

  logic accept;
  logic isData;
  logic [15:0] readValue;

  // A new request is taken on the edge that raises ack
  assign accept = req & ~ack;
  assign isData = (busReq.addr == AddrData);

  // One-shot strobes, a single cycle wide
  assign txPush = accept & busReq.write & isData;
  assign rxPop = accept & ~busReq.write & isData;
  assign timerLoad = accept & busReq.write & (busReq.addr == AddrTimeout);

  always_comb begin
    case (busReq.addr)
      AddrCtrl: begin
        readValue = {8'h00, ctrl.txEn, ctrl.rxEn, 1'b0, timerNz, sendBusy, 1'b0,
                     txFlags.canWrite, rxFlags.canRead};
      end
      AddrBaud: readValue = baud;
      AddrData: readValue = rxFlags.canRead ? {8'h00, rxHead} : 16'h0000;
      // Timeout count
      default: readValue = timerThis;
    endcase
  end

  always_ff @(posedge clkH) begin
    if (reset) begin
      ack <= 1'b0;
      ctrl <= '0;
      baud <= '0;
    end else begin
      if (accept) begin
        ack <= 1'b1;
      end else if (!req) begin
        ack <= 1'b0;
      end
      if (accept && busReq.write && busReq.addr == AddrCtrl) begin
        ctrl <= busReq.wdata[7:0];
      end
      if (accept && busReq.write && busReq.addr == AddrBaud) begin
        baud <= busReq.wdata;
      end
    end
  end

  // Read data is held for the whole ack phase
  always_ff @(posedge clkH) begin
    if (accept) begin
      rdata <= readValue;
    end
  end

  // Level interrupt from the enabled FIFO flags
  assign irq = |({txFlags.canWrite, rxFlags.canRead} & ctrl.irqEn);

endmodule

`default_nettype wire

// ==== source/uartFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartFifo (
  input wire clkH,
  input wire reset,
  input wire push,
  input wire uartPkg::byteT pushData,
  input wire pop,
  output uartPkg::byteT head,
  output uartPkg::fifoFlagsT flags
);
  import uartPkg::*;

  byteT mem [FifoDepth];
  logic [FifoAddrLen-1:0] rdPtr;
  logic [FifoAddrLen-1:0] wrPtr;
  logic [FifoAddrLen:0] count;
  logic full;
  logic empty;
  logic doPush;
  logic doPop;

  assign full = (count == (FifoAddrLen + 1)'(FifoDepth));
  assign empty = (count == '0);

  // Overflow and underflow requests are dropped
  assign doPush = push & ~full;
  assign doPop = pop & ~empty;

  always_ff @(posedge clkH) begin
    if (reset) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      if (doPush && !doPop) begin
        count <= count + 1'b1;
      end else if (doPop && !doPush) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clkH) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  assign head = mem[rdPtr];
  assign flags.canWrite = ~full;
  assign flags.canRead = ~empty;

endmodule

`default_nettype wire

// ==== source/uartTransmitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartTransmitter (
  input wire clkH,
  input wire reset,
  input wire uartPkg::uartCtrlT ctrl,
  input wire uartPkg::baudT baud,
  input wire ready,
  input wire uartPkg::byteT data,
  output logic pop,
  output logic txPin,
  output logic sendBusy
);
  import uartPkg::*;

  // Start bit, 8 data bits LSB first, up to two stop bits
  logic [10:0] shiftReg;
  logic [3:0] bitsLeft;
  baudT baudCnt;
  logic bitDone;

  // Take the FIFO head only when idle and enabled
  assign pop = ~sendBusy & ctrl.txEn & ready;
  assign bitDone = (baudCnt == '0);

  always_ff @(posedge clkH) begin
    if (reset) begin
      sendBusy <= 1'b0;
      bitsLeft <= '0;
      baudCnt <= '0;
    end else if (pop) begin
      sendBusy <= 1'b1;
      bitsLeft <= ctrl.twoStop ? 4'd11 : 4'd10;
      baudCnt <= baud - 16'd1;
    end else if (sendBusy) begin
      if (bitDone) begin
        baudCnt <= baud - 16'd1;
        bitsLeft <= bitsLeft - 4'd1;
        // Last stop bit has run its full length
        if (bitsLeft == 4'd1) begin
          sendBusy <= 1'b0;
        end
      end else begin
        baudCnt <= baudCnt - 16'd1;
      end
    end
  end

  always_ff @(posedge clkH) begin
    if (pop) begin
      shiftReg <= {2'b11, data, 1'b0};
    end else if (sendBusy && bitDone) begin
      shiftReg <= {1'b1, shiftReg[10:1]};
    end
  end

  // Line idles high between frames
  assign txPin = ~sendBusy | shiftReg[0];

endmodule

`default_nettype wire

// ==== source/uartReceiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartReceiver (
  input wire clkH,
  input wire reset,
  input wire uartPkg::uartCtrlT ctrl,
  input wire uartPkg::baudT baud,
  input wire rxPin,
  output uartPkg::byteT rxByte,
  output logic rxByteValid
);
  import uartPkg::*;

  // Two synchronizer stages plus one stage of history for edge detect
  logic [2:0] rxSync;
  logic rxIn;
  logic fallEdge;
  rxStateT state;
  baudT baudCnt;
  logic [2:0] bitIdx;
  byteT shiftReg;
  logic sampleNow;

  assign rxIn = rxSync[1];
  assign fallEdge = rxSync[2] & ~rxSync[1];
  assign sampleNow = (baudCnt == '0);

  always_ff @(posedge clkH) begin
    if (reset) begin
      rxSync <= 3'b111;
    end else begin
      rxSync <= {rxSync[1:0], rxPin};
    end
  end

  always_ff @(posedge clkH) begin
    if (reset) begin
      state <= RxIdle;
      baudCnt <= '0;
      bitIdx <= '0;
      rxByteValid <= 1'b0;
    end else begin
      rxByteValid <= 1'b0;
      if (!ctrl.rxEn) begin
        state <= RxIdle;
      end else begin
        baudCnt <= baudCnt - 16'd1;
        case (state)
          RxIdle: begin
            if (fallEdge) begin
              state <= RxStart;
              baudCnt <= (baud >> 1) - 16'd1;
            end
          end
          // Half a bit to reach the middle of the start bit
          RxStart: begin
            if (sampleNow) begin
              state <= RxData;
              baudCnt <= baud - 16'd1;
              bitIdx <= '0;
            end
          end
          RxData: begin
            if (sampleNow) begin
              baudCnt <= baud - 16'd1;
              bitIdx <= bitIdx + 3'd1;
              if (bitIdx == 3'd7) begin
                state <= RxStop;
              end
            end
          end
          // Stop bit level is not checked
          default: begin
            if (sampleNow) begin
              state <= RxIdle;
              rxByteValid <= 1'b1;
            end
          end
        endcase
      end
    end
  end

  // LSB arrives first
  always_ff @(posedge clkH) begin
    if (state == RxData && sampleNow) begin
      shiftReg <= {rxIn, shiftReg[7:1]};
    end
  end

  assign rxByte = shiftReg;

endmodule

`default_nettype wire

// ==== source/uartTimeout.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartTimeout (
  input wire clkH,
  input wire reset,
  input wire uartPkg::uartCtrlT ctrl,
  input wire sync1M,
  input wire sync1K,
  input wire load,
  input wire uartPkg::timerT loadValue,
  input wire restart,
  output uartPkg::timerT timerThis,
  output logic timerNz
);
  import uartPkg::*;

  timerT reload;
  logic tick;

  always_comb begin
    case (ctrl.timerSrc)
      TimerSrcStop: tick = 1'b0;
      TimerSrc1K: tick = sync1K;
      TimerSrc1M: tick = sync1M;
      TimerSrcClk: tick = 1'b1;
      default: tick = 1'b0;
    endcase
  end

  always_ff @(posedge clkH) begin
    if (reset) begin
      reload <= '0;
      timerThis <= '0;
    end else if (load) begin
      reload <= loadValue;
      timerThis <= loadValue;
    end else if (restart && ctrl.timerAutoRestart) begin
      // Line activity pushes the deadline out again
      timerThis <= reload;
    end else if (tick && timerNz) begin
      timerThis <= timerThis - 16'd1;
    end
  end

  assign timerNz = (timerThis != '0);

endmodule

`default_nettype wire

// ==== source/uartTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartTop (
  input wire clkH,
  input wire reset,
  input wire req,
  input wire uartPkg::busReqT busReq,
  input wire sync1M,
  input wire sync1K,
  input wire rxPin,
  output logic ack,
  output logic [15:0] rdata,
  output logic irq,
  output logic txPin,
  output logic sendBusy
);
  import uartPkg::*;

  uartCtrlT ctrl;
  baudT baud;
  fifoFlagsT txFlags;
  fifoFlagsT rxFlags;
  byteT txHead;
  byteT rxHead;
  byteT rxByte;
  timerT timerThis;
  logic txPush;
  logic rxPop;
  logic txPop;
  logic timerLoad;
  logic timerNz;
  logic rxByteValid;

  uartRegs regs (
    .clkH(clkH), .reset(reset), .req(req), .busReq(busReq),
    .txFlags(txFlags), .rxFlags(rxFlags), .rxHead(rxHead), .sendBusy(sendBusy),
    .timerThis(timerThis), .timerNz(timerNz), .ack(ack), .rdata(rdata),
    .ctrl(ctrl), .baud(baud), .txPush(txPush), .rxPop(rxPop),
    .timerLoad(timerLoad), .irq(irq)
  );

  uartFifo txFifo (
    .clkH(clkH), .reset(reset), .push(txPush), .pushData(busReq.wdata[7:0]),
    .pop(txPop), .head(txHead), .flags(txFlags)
  );

  uartFifo rxFifo (
    .clkH(clkH), .reset(reset), .push(rxByteValid), .pushData(rxByte),
    .pop(rxPop), .head(rxHead), .flags(rxFlags)
  );

  uartTransmitter transmitter (
    .clkH(clkH), .reset(reset), .ctrl(ctrl), .baud(baud),
    .ready(txFlags.canRead), .data(txHead), .pop(txPop), .txPin(txPin),
    .sendBusy(sendBusy)
  );

  uartReceiver receiver (
    .clkH(clkH), .reset(reset), .ctrl(ctrl), .baud(baud), .rxPin(rxPin),
    .rxByte(rxByte), .rxByteValid(rxByteValid)
  );

  // Any traffic on either line restarts the timer
  uartTimeout timer (
    .clkH(clkH), .reset(reset), .ctrl(ctrl), .sync1M(sync1M), .sync1K(sync1K),
    .load(timerLoad), .loadValue(busReq.wdata), .restart(sendBusy | rxByteValid),
    .timerThis(timerThis), .timerNz(timerNz)
  );

endmodule

`default_nettype wire

// ==== verification/uartClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartClockGen (
  output logic clkH
);

  // 20 ns period, starts low
  initial begin
    clkH = 1'b0;
    forever #10 clkH = ~clkH;
  end

endmodule

`default_nettype wire

// ==== verification/uartTop_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartTop_sva (
  input wire clkH,
  input wire reset,
  input wire req,
  input wire ack,
  input wire [15:0] rdata,
  input wire txPin,
  input wire sendBusy
);

  int failCount = 0;

  // Four-phase handshake
  reqGetsAck: assert property (@(posedge clkH) disable iff (reset) req && !ack |=> ack)
    else begin
      failCount++;
      $error("ack did not rise one cycle after req");
    end

  ackDropsAfterReq: assert property (@(posedge clkH) disable iff (reset) ack && !req |=> !ack)
    else begin
      failCount++;
      $error("ack stayed high after req fell");
    end

  ackNeedsReq: assert property (@(posedge clkH) disable iff (reset) $rose(ack) |-> $past(req))
    else begin
      failCount++;
      $error("ack rose without a request");
    end

  // Read data held through the ack phase
  rdataHeld: assert property (@(posedge clkH) disable iff (reset)
      ack && $past(ack) |-> $stable(rdata))
    else begin
      failCount++;
      $error("rdata changed while ack was high");
    end

  // Every frame ends on a stop bit
  stopBitLast: assert property (@(posedge clkH) disable iff (reset)
      $fell(sendBusy) |-> $past(txPin))
    else begin
      failCount++;
      $error("txPin was low in the last bit of a frame");
    end

endmodule

bind uartTop uartTop_sva assertions (
  .clkH(clkH), .reset(reset), .req(req), .ack(ack), .rdata(rdata),
  .txPin(txPin), .sendBusy(sendBusy)
);

`default_nettype wire

// ==== verification/uartTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartTb;
  import uartPkg::*;

  localparam int CycleLimit = 20000;

  logic clkH;
  logic reset;
  logic req;
  busReqT busReq;
  logic sync1M;
  logic sync1K;
  logic rxPin;
  logic ack;
  logic [15:0] rdata;
  logic irq;
  logic txPin;
  logic sendBusy;

  int unsigned lcgState = 33;
  int cycles = 0;
  int bitClocks = 8;
  int framesSeen = 0;
  logic [10:0] expFrames[$];
  int expLens[$];
  byteT txBytes[3];
  byteT rxBytes[5];
  byteT oneByte;
  logic [15:0] value;
  logic [15:0] earlier;

  uartClockGen clockGen (.clkH(clkH));

  uartTop uartTop_i (
    .clkH(clkH), .reset(reset), .req(req), .busReq(busReq), .sync1M(sync1M),
    .sync1K(sync1K), .rxPin(rxPin), .ack(ack), .rdata(rdata), .irq(irq),
    .txPin(txPin), .sendBusy(sendBusy)
  );

  function automatic byteT lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[23:16];
  endfunction

  // Expected line level of each bit of a frame starting with the start bit
  function automatic logic [10:0] refFrame(input byteT data);
    logic [10:0] frame;
    frame = '1;
    frame[0] = 1'b0;
    for (int i = 0; i < 8; i++) begin
      frame[i + 1] = data[i];
    end
    return frame;
  endfunction

  function automatic logic [15:0] statusWord(input logic txEn, input logic rxEn,
                                             input logic timerNz, input logic busy,
                                             input logic canWrite, input logic canRead);
    return {8'h00, txEn, rxEn, 1'b0, timerNz, busy, 1'b0, canWrite, canRead};
  endfunction

  task automatic checkEq(input logic [15:0] actual, input logic [15:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns: %s, got 0x%04h, expected 0x%04h", $time, what, actual,
               expected);
      $display("Some tests failed");
      $fatal(1, "check failed");
    end
  endtask

  task automatic writeReg(input regAddrT addr, input logic [15:0] data);
    busReq.write = 1'b1;
    busReq.addr = addr;
    busReq.wdata = data;
    req = 1'b1;
    do @(negedge clkH); while (!ack);
    req = 1'b0;
    do @(negedge clkH); while (ack);
  endtask

  task automatic readReg(input regAddrT addr, output logic [15:0] data);
    busReq.write = 1'b0;
    busReq.addr = addr;
    busReq.wdata = '0;
    req = 1'b1;
    do @(negedge clkH); while (!ack);
    data = rdata;
    req = 1'b0;
    do @(negedge clkH); while (ack);
  endtask

  // One frame with a single stop bit
  task automatic driveSerial(input byteT data);
    logic [10:0] frame;
    frame = refFrame(data);
    for (int i = 0; i < 10; i++) begin
      rxPin = frame[i];
      repeat (bitClocks) @(negedge clkH);
    end
  endtask

  task automatic waitFrames(input int count);
    while (framesSeen < count) @(negedge clkH);
    while (sendBusy) @(negedge clkH);
  endtask

  // TX decoder sampling each bit near its middle
  initial begin : frameMonitor
    logic [10:0] seen;
    logic [10:0] want;
    int nBits;
    forever begin
      @(negedge clkH);
      if (!reset && txPin === 1'b0) begin
        if (expFrames.size() == 0) begin
          $display("[FAIL] %0t ns: start bit on txPin with no byte queued", $time);
          $display("Some tests failed");
          $fatal(1, "unexpected frame");
        end else begin
          want = expFrames.pop_front();
          nBits = expLens.pop_front();
          seen = '1;
          repeat (bitClocks / 2 - 1) @(negedge clkH);
          for (int i = 0; i < nBits; i++) begin
            if (i > 0) repeat (bitClocks) @(negedge clkH);
            seen[i] = txPin;
            checkEq(16'(sendBusy), 16'd1, "sendBusy inside frame");
          end
          checkEq(16'(seen), 16'(want), "TX frame");
          framesSeen++;
        end
      end
    end
  end

  always @(posedge clkH) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Run stopped after %0d cycles before the tests finished", cycles);
      $display("Some tests failed");
      $fatal(1, "cycle limit");
    end
  end

  initial begin
    reset = 1'b1;
    req = 1'b0;
    busReq = '0;
    sync1M = 1'b0;
    sync1K = 1'b0;
    rxPin = 1'b1;
    repeat (10) @(negedge clkH);
    reset = 1'b0;

    checkEq(16'(txPin), 16'd1, "txPin after reset");
    checkEq(16'(irq), 16'd0, "irq after reset");
    readReg(AddrCtrl, value);
    checkEq(value, statusWord(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0), "control after reset");
    readReg(AddrTimeout, value);
    checkEq(value, 16'd0, "timeout after reset");

    // Register readback with the timer stopped
    writeReg(AddrCtrl, 16'h00C0);
    readReg(AddrCtrl, value);
    checkEq(value, statusWord(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0), "control readback");
    writeReg(AddrBaud, 16'd8);
    readReg(AddrBaud, value);
    checkEq(value, 16'd8, "baud readback");

    // Transmit three bytes and then one with two stop bits
    for (int i = 0; i < 3; i++) begin
      txBytes[i] = lcgNext();
      expFrames.push_back(refFrame(txBytes[i]));
      expLens.push_back(10);
    end
    for (int i = 0; i < 3; i++) begin
      writeReg(AddrData, {8'h00, txBytes[i]});
    end
    waitFrames(3);
    readReg(AddrCtrl, value);
    checkEq(value, statusWord(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0), "status after TX");
    writeReg(AddrCtrl, 16'h00C8);
    oneByte = lcgNext();
    expFrames.push_back(refFrame(oneByte));
    expLens.push_back(11);
    writeReg(AddrData, {8'h00, oneByte});
    waitFrames(4);
    writeReg(AddrCtrl, 16'h00C0);

    // Receive five bytes into a four-entry FIFO
    for (int i = 0; i < 5; i++) begin
      rxBytes[i] = lcgNext();
      driveSerial(rxBytes[i]);
    end
    repeat (bitClocks) @(negedge clkH);
    for (int i = 0; i < 4; i++) begin
      readReg(AddrData, value);
      checkEq(value, 16'(rxBytes[i]), "RX byte");
    end
    readReg(AddrCtrl, value);
    checkEq(value, statusWord(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0), "canRead after RX");
    readReg(AddrData, value);
    checkEq(value, 16'd0, "read of empty RX FIFO");

    // Interrupt on RX data and then on TX space
    writeReg(AddrCtrl, 16'h00C1);
    checkEq(16'(irq), 16'd0, "irq with RX FIFO empty");
    oneByte = lcgNext();
    driveSerial(oneByte);
    while (!irq) @(negedge clkH);
    readReg(AddrData, value);
    checkEq(value, 16'(oneByte), "RX byte behind irq");
    checkEq(16'(irq), 16'd0, "irq after RX read");
    writeReg(AddrCtrl, 16'h00C2);
    checkEq(16'(irq), 16'd1, "irq on TX space");

    // Timer counting every clock
    writeReg(AddrCtrl, 16'h00F0);
    writeReg(AddrTimeout, 16'd100);
    readReg(AddrTimeout, earlier);
    readReg(AddrTimeout, value);
    checkEq(16'(earlier != 16'd0 && value != 16'd0), 16'd1, "timer nonzero");
    checkEq(16'(earlier > value), 16'd1, "timer decreasing");
    readReg(AddrCtrl, value);
    checkEq(value, statusWord(1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0), "timerNz while counting");
    repeat (120) @(negedge clkH);
    readReg(AddrTimeout, value);
    checkEq(value, 16'd0, "timer expired");
    readReg(AddrCtrl, value);
    checkEq(value, statusWord(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0), "timerNz after expiry");

    if (uartTop_i.assertions.failCount == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("%0d assertion failures during the run", uartTop_i.assertions.failCount);
      $display("Some tests failed");
      $fatal(1, "assertion failures");
    end
  end

endmodule

`default_nettype wire

// ==== build.f ====
source/uartPkg.sv
source/uartRegs.sv
source/uartFifo.sv
source/uartTransmitter.sv
source/uartReceiver.sv
source/uartTimeout.sv
source/uartTop.sv
verification/uartClockGen.sv
verification/uartTop_sva.sv
verification/uartTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module uartTb -Mdir obj_dir -o uartSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/uartSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
